// ==== hdl/adc_pkg.sv ====
package adc_pkg;

	//////////////////////////////
	// ADC side widths
	//////////////////////////////

	localparam int ADC_SAMPLE_W  = 16; // One converter channel
	localparam int SAMPLE_WORD_W = 2 * ADC_SAMPLE_W; // A and B side by side

	// One channel sample as the converter delivers it
	typedef logic [ADC_SAMPLE_W-1:0] adc_sample_t;

	// Channel A in the upper half, channel B in the lower half
	typedef logic [SAMPLE_WORD_W-1:0] sample_word_t;

endpackage

// ==== hdl/eth_pkg.sv ====
package eth_pkg;

	//////////////////////////////
	// Output stream format
	//////////////////////////////

	localparam int STREAM_WORD_W  = 32; // Payload per beat
	localparam int STREAM_FLAGS_W = 2;

	// Flag bit positions
	localparam int FLAG_SOF = 1; // First word of a frame
	localparam int FLAG_EOF = 0; // Last word of a frame

	typedef logic [STREAM_WORD_W-1:0]  stream_word_t;
	typedef logic [STREAM_FLAGS_W-1:0] stream_flags_t;

	//////////////////////////////
	// Sender FSM
	//////////////////////////////

	typedef enum logic [1:0]
	{
		SEND_IDLE,    // Waiting for a full packet on either source
		SEND_PRIMARY, // Config data, wins over ADC
		SEND_ADC
	} sender_state_t;

endpackage

// ==== hdl/adc_sample_packer.sv ====
module adc_sample_packer
	import adc_pkg::*;
(
	input  logic         GMII_GTX_CLK_int,
	input  logic         rst_n_i,

	// Parallel samples from the converter
	input  logic         sample_valid_i,
	input  adc_sample_t  cha_i,
	input  adc_sample_t  chb_i,

	// FIFO write side
	input  logic         fifo_full_i,
	output logic         wr_en_o,
	output sample_word_t wr_data_o,

	output logic         overflow_o // Sticky until reset
);

	logic pend_q; // Packed word waiting for its write slot

	//////////////////////////////
	// Capture
	//////////////////////////////

	// Payload register
	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (sample_valid_i)
			wr_data_o <= {cha_i, chb_i}; // A high, B low
	end

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			pend_q     <= 1'b0;
			overflow_o <= 1'b0;
		end
		else
		begin
			pend_q <= sample_valid_i;
			if (pend_q && fifo_full_i)
				overflow_o <= 1'b1; // Word is lost
		end
	end

	// Full is checked in the write cycle itself, since a write from the
	// previous cycle may just have filled the last slot
	assign wr_en_o = pend_q & ~fifo_full_i;

endmodule

// ==== hdl/sample_fifo.sv ====
module sample_fifo
	import adc_pkg::*;
#(
	parameter int FIFO_DEPTH       = 512,
	parameter int ADC_PACKET_WORDS = 128
)
(
	input  logic         GMII_GTX_CLK_int,
	input  logic         rst_n_i,

	// Write side
	input  logic         wr_en_i,
	input  sample_word_t wr_data_i,
	output logic         full_o,

	// Read side, head word shown ahead of the pop
	input  logic         rd_en_i,
	output sample_word_t rd_data_o,
	output logic         packet_ready_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int LVL_W = $clog2(FIFO_DEPTH + 1); // Must hold FIFO_DEPTH itself

	typedef logic [PTR_W-1:0] fifo_ptr_t;
	typedef logic [LVL_W-1:0] fifo_level_t;

	sample_word_t mem [FIFO_DEPTH];
	fifo_ptr_t    wr_ptr;
	fifo_ptr_t    rd_ptr;
	fifo_level_t  level;
	logic         empty;
	logic         do_wr;
	logic         do_rd;

	// Wrap at FIFO_DEPTH, which need not be a power of two
	function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
		if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1))
			return '0;
		else
			return ptr + fifo_ptr_t'(1);
	endfunction

	assign empty  = (level == '0);
	assign full_o = (level == fifo_level_t'(FIFO_DEPTH));
	assign do_wr  = wr_en_i & ~full_o;
	assign do_rd  = rd_en_i & ~empty;

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
	end

	assign rd_data_o = mem[rd_ptr]; // Show-ahead

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_next(rd_ptr);

			case ({do_wr, do_rd})
				2'b10:   level <= level + fifo_level_t'(1);
				2'b01:   level <= level - fifo_level_t'(1);
				default: level <= level; // Both or neither
			endcase
		end
	end

	// A whole packet is here, so the sender can run it to the end
	assign packet_ready_o = (level >= fifo_level_t'(ADC_PACKET_WORDS));

	//////////////////////////////
	// Checks
	//////////////////////////////

	a_no_read_empty : assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		rd_en_i |-> !empty
	) else $error("pop from an empty sample FIFO");

	a_no_write_full : assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		wr_en_i |-> !full_o
	) else $error("push into a full sample FIFO");

endmodule

// ==== hdl/packet_sender.sv ====
module packet_sender
	import adc_pkg::*;
	import eth_pkg::*;
#(
	parameter int PRI_PACKET_WORDS = 128,
	parameter int ADC_PACKET_WORDS = 128
)
(
	input  logic          GMII_GTX_CLK_int,
	input  logic          rst_n_i,

	// Primary source, configuration data
	input  logic          pri_req_i,  // Whole packet waiting
	input  stream_word_t  pri_data_i, // Head word
	output logic          pri_rd_o,

	// ADC source, from the sample FIFO
	input  logic          adc_ready_i,
	input  sample_word_t  adc_data_i,
	output logic          adc_rd_o,

	// Output stream
	output stream_word_t  tx_data_o,
	output stream_flags_t tx_flags_o,
	output logic          tx_src_rdy_o,
	input  logic          tx_dst_rdy_i
);

	localparam int MAX_WORDS =
		(PRI_PACKET_WORDS > ADC_PACKET_WORDS) ? PRI_PACKET_WORDS : ADC_PACKET_WORDS;
	localparam int CNT_W = $clog2(MAX_WORDS + 1);

	typedef logic [CNT_W-1:0] word_cnt_t;

	sender_state_t state;
	word_cnt_t     word_cnt;  // Index of the current beat in the packet
	word_cnt_t     last_idx;
	logic          last_word;
	logic          xfer;

	//////////////////////////////
	// Beat control
	//////////////////////////////

	// Packet length follows the source in use
	assign last_idx = (state == SEND_PRIMARY) ? word_cnt_t'(PRI_PACKET_WORDS - 1)
	                                          : word_cnt_t'(ADC_PACKET_WORDS - 1);
	assign last_word = (word_cnt == last_idx);

	assign tx_src_rdy_o = (state != SEND_IDLE); // One cycle after the pick
	assign xfer         = tx_src_rdy_o & tx_dst_rdy_i;

	// Pop exactly once per transferred beat
	assign pri_rd_o = xfer & (state == SEND_PRIMARY);
	assign adc_rd_o = xfer & (state == SEND_ADC);

	//////////////////////////////
	// Data and flags
	//////////////////////////////

	// Heads only move on a pop, so a stalled beat holds still
	assign tx_data_o = (state == SEND_ADC) ? stream_word_t'(adc_data_i) : pri_data_i;

	always_comb
	begin
		tx_flags_o           = '0;
		tx_flags_o[FLAG_SOF] = tx_src_rdy_o && (word_cnt == '0);
		tx_flags_o[FLAG_EOF] = tx_src_rdy_o && last_word;
	end

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int)
	begin
		if (!rst_n_i)
		begin
			state    <= SEND_IDLE;
			word_cnt <= '0;
		end
		else
		begin
			case (state)
				SEND_IDLE:
				begin
					word_cnt <= '0;
					if (pri_req_i)
						state <= SEND_PRIMARY; // Config data first
					else if (adc_ready_i)
						state <= SEND_ADC;
				end

				SEND_PRIMARY, SEND_ADC:
				begin
					if (xfer)
					begin
						if (last_word)
						begin
							state    <= SEND_IDLE; // Next pick only after EOF
							word_cnt <= '0;
						end
						else
							word_cnt <= word_cnt + word_cnt_t'(1);
					end
				end

				default:
				begin
					state    <= SEND_IDLE;
					word_cnt <= '0;
				end
			endcase
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Covers the FIFO and primary heads as well as this block
	a_stall_stable : assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (!rst_n_i)
		(tx_src_rdy_o && !tx_dst_rdy_i) |=>
			(tx_src_rdy_o && $stable(tx_data_o) && $stable(tx_flags_o))
	) else $error("stream beat changed while stalled");

endmodule

// ==== hdl/adc_eth_top.sv ====
module adc_eth_top
	import adc_pkg::*;
	import eth_pkg::*;
#(
	parameter int FIFO_DEPTH       = 512,
	parameter int PRI_PACKET_WORDS = 128,
	parameter int ADC_PACKET_WORDS = 128 // Also the FIFO threshold
)
(
	input  logic          GMII_GTX_CLK_int,
	input  logic          rst_n_i, // Low until the MAC is up

	// ADC samples
	input  logic          sample_valid_i,
	input  adc_sample_t   cha_i,
	input  adc_sample_t   chb_i,

	// Configuration data source
	input  logic          pri_req_i,
	input  stream_word_t  pri_data_i,
	output logic          pri_rd_o,

	// Flagged stream towards the MAC
	output stream_word_t  tx_data_o,
	output stream_flags_t tx_flags_o,
	output logic          tx_src_rdy_o,
	input  logic          tx_dst_rdy_i,

	output logic          overflow_o
);

	// Packer to FIFO
	logic         fifo_wr_en;
	sample_word_t fifo_wr_data;
	logic         fifo_full;

	// FIFO to sender
	logic         fifo_rd_en;
	sample_word_t fifo_rd_data;
	logic         fifo_packet_ready;

	adc_sample_packer u_packer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.sample_valid_i   (sample_valid_i),
		.cha_i            (cha_i),
		.chb_i            (chb_i),
		.fifo_full_i      (fifo_full),
		.wr_en_o          (fifo_wr_en),
		.wr_data_o        (fifo_wr_data),
		.overflow_o       (overflow_o)
	);

	sample_fifo #(
		.FIFO_DEPTH       (FIFO_DEPTH),
		.ADC_PACKET_WORDS (ADC_PACKET_WORDS)
	) u_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.wr_en_i          (fifo_wr_en),
		.wr_data_i        (fifo_wr_data),
		.full_o           (fifo_full),
		.rd_en_i          (fifo_rd_en),
		.rd_data_o        (fifo_rd_data),
		.packet_ready_o   (fifo_packet_ready)
	);

	packet_sender #(
		.PRI_PACKET_WORDS (PRI_PACKET_WORDS),
		.ADC_PACKET_WORDS (ADC_PACKET_WORDS)
	) u_sender (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.pri_req_i        (pri_req_i),
		.pri_data_i       (pri_data_i),
		.pri_rd_o         (pri_rd_o),
		.adc_ready_i      (fifo_packet_ready),
		.adc_data_i       (fifo_rd_data),
		.adc_rd_o         (fifo_rd_en),
		.tx_data_o        (tx_data_o),
		.tx_flags_o       (tx_flags_o),
		.tx_src_rdy_o     (tx_src_rdy_o),
		.tx_dst_rdy_i     (tx_dst_rdy_i)
	);

endmodule

// ==== test/tb_adc_eth.sv ====
module tb_adc_eth
	import adc_pkg::*;
	import eth_pkg::*;
();

	localparam int FIFO_DEPTH   = 32;
	localparam int PRI_WORDS    = 8;
	localparam int ADC_WORDS    = 16;
	localparam int BEAT_TIMEOUT = 200; // Idle cycles allowed before the next beat

	logic          GMII_GTX_CLK_int;
	logic          rst_n_i;
	logic          sample_valid_i;
	adc_sample_t   cha_i;
	adc_sample_t   chb_i;
	logic          pri_req_i;
	stream_word_t  pri_data_i;
	logic          pri_rd_o;
	stream_word_t  tx_data_o;
	stream_flags_t tx_flags_o;
	logic          tx_src_rdy_o;
	logic          tx_dst_rdy_i;
	logic          overflow_o;

	logic [15:0]   lfsr_state;
	stream_word_t  exp_q[$];               // Packed pairs in arrival order
	stream_word_t  pri_mem [PRI_WORDS];    // Primary packet model

	adc_eth_top #(
		.FIFO_DEPTH       (FIFO_DEPTH),
		.PRI_PACKET_WORDS (PRI_WORDS),
		.ADC_PACKET_WORDS (ADC_WORDS)
	) uut (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_n_i          (rst_n_i),
		.sample_valid_i   (sample_valid_i),
		.cha_i            (cha_i),
		.chb_i            (chb_i),
		.pri_req_i        (pri_req_i),
		.pri_data_i       (pri_data_i),
		.pri_rd_o         (pri_rd_o),
		.tx_data_o        (tx_data_o),
		.tx_flags_o       (tx_flags_o),
		.tx_src_rdy_o     (tx_src_rdy_o),
		.tx_dst_rdy_i     (tx_dst_rdy_i),
		.overflow_o       (overflow_o)
	);

	initial
	begin
		GMII_GTX_CLK_int = 1'b0;
		forever #4 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
	end

	//////////////////////////////
	// LFSR and checks
	//////////////////////////////

	// Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic take_bit();
		logic lsb;
		lsb        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 16'hB400;
		return lsb;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
			val = {val[30:0], take_bit()}; // One step per bit
		return val;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input stream_word_t exp, input stream_word_t act);
		if (act !== exp)
		begin
			$display("Fail at time %0t: %s expected %h, got %h", $time, name, exp, act);
			abort_run("stream data mismatch");
		end
	endtask

	task automatic check_flags(input string name, input stream_flags_t exp,
		input stream_flags_t act);
		if (act !== exp)
		begin
			$display("Fail at time %0t: %s expected %b, got %b", $time, name, exp, act);
			abort_run("stream flags mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Fail at time %0t: %s expected %b, got %b", $time, name, exp, act);
			abort_run("control bit mismatch");
		end
	endtask

	//////////////////////////////
	// Drivers and monitors
	//////////////////////////////

	task automatic reset_dut();
		@(posedge GMII_GTX_CLK_int);
		#1;
		rst_n_i        = 1'b0;
		sample_valid_i = 1'b0;
		repeat (10) @(posedge GMII_GTX_CLK_int);
		#1;
		rst_n_i = 1'b1;
	endtask

	task automatic set_dst_rdy(input logic val);
		@(posedge GMII_GTX_CLK_int);
		#1;
		tx_dst_rdy_i = val;
	endtask

	// One pair per cycle with only the first keep pairs expected out
	task automatic push_pairs(input int n, input int keep);
		for (int i = 0; i < n; i++)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
			sample_valid_i = 1'b1;
			cha_i          = adc_sample_t'(take_bits(16));
			chb_i          = adc_sample_t'(take_bits(16));
			if (i < keep)
				exp_q.push_back({cha_i, chb_i}); // A above B
		end
		@(posedge GMII_GTX_CLK_int);
		#1;
		sample_valid_i = 1'b0;
	endtask

	task automatic load_primary();
		for (int i = 0; i < PRI_WORDS; i++)
			pri_mem[i] = take_bits(32);
		pri_data_i = pri_mem[0];
		pri_req_i  = 1'b1;
	endtask

	// A beat seen at the falling edge transfers on the next rising edge
	task automatic receive_packet(input logic from_pri, input int words, input logic random_rdy);
		int            k;
		int            idle;
		logic          pop_pend;
		stream_word_t  exp_w;
		stream_flags_t exp_f;
		k        = 0;
		idle     = 0;
		pop_pend = 1'b0;
		while (k < words)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
			if (pop_pend)
				pri_data_i = pri_mem[k]; // Next primary head
			pop_pend     = 1'b0;
			tx_dst_rdy_i = random_rdy ? take_bit() : 1'b1;
			@(negedge GMII_GTX_CLK_int);
			if (tx_src_rdy_o && tx_dst_rdy_i)
			begin
				if (from_pri)
					exp_w = pri_mem[k];
				else if (exp_q.size() == 0)
					abort_run("an ADC beat arrived with no sample left to expect");
				else
					exp_w = exp_q.pop_front();
				exp_f           = '0;
				exp_f[FLAG_SOF] = (k == 0);
				exp_f[FLAG_EOF] = (k == words - 1);
				check_word("tx_data_o", exp_w, tx_data_o);
				check_flags("tx_flags_o", exp_f, tx_flags_o);
				check_bit("pri_rd_o", from_pri, pri_rd_o);
				pop_pend = from_pri;
				k++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > BEAT_TIMEOUT)
					abort_run("timeout while waiting for the next stream beat");
			end
		end
		if (from_pri)
		begin
			@(posedge GMII_GTX_CLK_int);
			#1;
			pri_req_i = 1'b0; // Whole packet read out
		end
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge GMII_GTX_CLK_int);
			check_bit("tx_src_rdy_o", 1'b0, tx_src_rdy_o);
		end
	endtask

	task automatic wait_overflow(input int limit);
		int n;
		n = 0;
		while (overflow_o !== 1'b1)
		begin
			@(negedge GMII_GTX_CLK_int);
			n++;
			if (n > limit)
				abort_run("overflow_o never rose after the FIFO filled up");
		end
	endtask

	task automatic ensure_queue_drained();
		if (exp_q.size() != 0)
			abort_run("expected sample words were never sent");
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic send_one_adc_packet();
		set_dst_rdy(1'b1);
		push_pairs(ADC_WORDS, ADC_WORDS);
		receive_packet(1'b0, ADC_WORDS, 1'b0);
		expect_idle(20); // No 17th beat
		ensure_queue_drained();
	endtask

	task automatic hold_below_threshold();
		set_dst_rdy(1'b1);
		push_pairs(ADC_WORDS - 1, ADC_WORDS - 1);
		expect_idle(60);
		push_pairs(1, 1);
		receive_packet(1'b0, ADC_WORDS, 1'b0);
		ensure_queue_drained();
	endtask

	task automatic primary_wins_arbitration();
		set_dst_rdy(1'b1);
		push_pairs(ADC_WORDS, ADC_WORDS);
		@(posedge GMII_GTX_CLK_int); // Last pair lands in the FIFO here
		#1;
		load_primary(); // Request rises together with packet_ready
		receive_packet(1'b1, PRI_WORDS, 1'b0);
		receive_packet(1'b0, ADC_WORDS, 1'b0);
		ensure_queue_drained();
	endtask

	task automatic stall_under_back_pressure();
		set_dst_rdy(1'b0);
		push_pairs(2 * ADC_WORDS, 2 * ADC_WORDS);
		receive_packet(1'b0, ADC_WORDS, 1'b1);
		receive_packet(1'b0, ADC_WORDS, 1'b1);
		ensure_queue_drained();
		@(negedge GMII_GTX_CLK_int);
		check_bit("overflow_o", 1'b0, overflow_o);
	endtask

	task automatic drop_on_overflow();
		set_dst_rdy(1'b0);
		push_pairs(40, FIFO_DEPTH); // Last 8 pairs are dropped
		wait_overflow(20);
		receive_packet(1'b0, ADC_WORDS, 1'b0);
		receive_packet(1'b0, ADC_WORDS, 1'b0);
		expect_idle(40);
		ensure_queue_drained();
		@(negedge GMII_GTX_CLK_int);
		check_bit("overflow_o", 1'b1, overflow_o); // Sticky
		reset_dut();
		@(negedge GMII_GTX_CLK_int);
		check_bit("overflow_o", 1'b0, overflow_o);
	endtask

	initial
	begin
		rst_n_i        = 1'b0;
		sample_valid_i = 1'b0;
		cha_i          = '0;
		chb_i          = '0;
		pri_req_i      = 1'b0;
		pri_data_i     = '0;
		tx_dst_rdy_i   = 1'b0;
		lfsr_state     = 16'd70;
		reset_dut();
		@(negedge GMII_GTX_CLK_int);
		check_bit("tx_src_rdy_o", 1'b0, tx_src_rdy_o);
		check_bit("pri_rd_o", 1'b0, pri_rd_o);
		check_bit("overflow_o", 1'b0, overflow_o);
		send_one_adc_packet();
		hold_below_threshold();
		primary_wins_arbitration();
		stall_under_back_pressure();
		drop_on_overflow();
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
hdl/adc_pkg.sv
hdl/eth_pkg.sv
hdl/adc_sample_packer.sv
hdl/sample_fifo.sv
hdl/packet_sender.sv
hdl/adc_eth_top.sv
test/tb_adc_eth.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_adc_eth
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
